//--- Bender.yml
package:
  name: spim

sources:
  # Packages and the interface come before the modules that use them
  - verilog/spim_cmd_pkg.sv
  - verilog/spim_link_pkg.sv
  - verilog/spim_tx_if.sv
  - verilog/spim_clkgen.sv
  - verilog/spim_tx.sv
  - verilog/spim_rx.sv
  - verilog/spim_seq_fsm.sv
  - verilog/spim_top.sv
  - target: test
    files:
      - verif/spim_chk.sv
      - verif/spim_tb.sv

//--- verif/spim_chk.sv
module spim_chk (
  input logic                             clk,
  input logic                             rstn,
  input logic                             cmd_valid,
  input logic                             cmd_ready,
  input logic                             res_valid,
  input logic                             res_ready,
  input logic [spim_link_pkg::WORD_W-1:0] res_data,
  input logic                             busy,
  input logic                             spi_clk,
  input logic                             spi_csn
);

  // Count of failed assertions
  int fails = 0;

  // SPI clock parks low outside a frame
  sclk_idle_a: assert property (@(posedge clk) disable iff (!rstn)
    spi_csn |-> !spi_clk)
    else begin
      $error("spi_clk high while spi_csn is high");
      fails++;
    end

  // Response word waits with stable data until taken
  res_hold_a: assert property (@(posedge clk) disable iff (!rstn)
    res_valid && !res_ready |=> res_valid && $stable(res_data))
    else begin
      $error("res_valid or res_data changed before res_ready");
      fails++;
    end

  // No further word is taken in the cycle after a header opens a frame
  hdr_frame_a: assert property (@(posedge clk) disable iff (!rstn)
    cmd_valid && cmd_ready && !busy |=> busy && !cmd_ready)
    else begin
      $error("cmd_ready high during chip-select setup");
      fails++;
    end

endmodule

bind spim_top spim_chk i_chk (.*);

//--- verif/spim_tb.sv
module spim_tb;
  import spim_cmd_pkg::*;
  import spim_link_pkg::*;

  // Limit well above the combined length of the five tests
  localparam int TIMEOUT_CYCLES = 20000;

  logic                clk;
  logic                rstn;
  logic [CLKDIV_W-1:0] clk_div;
  logic                cmd_valid;
  logic                cmd_ready;
  logic [WORD_W-1:0]   cmd_data;
  logic                res_valid;
  logic                res_ready;
  logic [WORD_W-1:0]   res_data;
  logic                busy;
  logic                spi_clk;
  logic                spi_csn;
  logic                spi_sdo;
  logic                spi_sdi;

  int                  errors;
  int                  checks;
  int                  cycles;
  integer              seed;
  logic                rand_ready;
  // Rising spi_clk edges seen in the current frame
  int                  sbit;
  logic                cap_bits[$];
  int                  frame_len[$];
  logic [WORD_W-1:0]   resp_q[$];

  spim_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d clk cycles, the DUT stopped making progress", cycles);
    $display("*** FAILED ***");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Response ready is random only while rand_ready is set
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    if (rand_ready) begin
      res_ready <= $random(seed);
    end else begin
      res_ready <= 1'b1;
    end
  end

  // Valid and ready both high here means the word moves on the next edge
  always @(negedge clk) begin
    if (res_valid && res_ready) begin
      resp_q.push_back(res_data);
    end
  end

  // ----------------------------------------------------------------------
  // SPI slave model in mode 0
  // ----------------------------------------------------------------------
  function automatic logic [7:0] slave_byte(input int k);
    return 8'h5a ^ 8'(k * 29);
  endfunction

  function automatic logic slave_bit(input int n);
    logic [7:0] b;
    b = slave_byte(n / 8);
    return b[7 - (n % 8)];
  endfunction

  // First bit goes out before the first rising edge
  always @(negedge spi_csn) begin
    sbit    <= 0;
    spi_sdi <= slave_bit(0);
  end

  always @(posedge spi_clk) begin
    if (spi_csn) begin
      errors++;
      $display("spi_clk rose while spi_csn was high");
    end else begin
      cap_bits.push_back(spi_sdo);
      sbit <= sbit + 1;
    end
  end

  // Next bit shows up on the falling edge
  always @(negedge spi_clk) begin
    if (!spi_csn) begin
      spi_sdi <= slave_bit(sbit);
    end
  end

  always @(posedge spi_csn) begin
    frame_len.push_back(sbit);
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  // Expected response word with the first byte on the wire in bits 7:0
  function automatic logic [31:0] read_word(input int first);
    logic [31:0] w;
    for (int k = 0; k < 4; k++) begin
      w[8*k +: 8] = slave_byte(first + k);
    end
    return w;
  endfunction

  // Byte k of all captured spi_sdo bits taken MSB first
  function automatic logic [7:0] sent_byte(input int k);
    logic [7:0] b;
    b = 'x;
    if (cap_bits.size() >= 8*k + 8) begin
      for (int i = 0; i < 8; i++) begin
        b[7-i] = cap_bits[8*k + i];
      end
    end
    return b;
  endfunction

  function automatic logic [31:0] make_hdr(input logic [7:0] op, input seq_e sq,
                                           input size_e asz, input size_e dsz,
                                           input logic [7:0] nbytes);
    cmd_word_t w;
    w.raw            = '0;
    w.hdr.opcode     = op;
    w.hdr.seq        = sq;
    w.hdr.addr_size  = asz;
    w.hdr.dummy_size = dsz;
    w.hdr.data_bytes = nbytes;
    return w.raw;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic expect_frames(input int n);
    checks++;
    if (frame_len.size() != n) begin
      errors++;
      $display("Saw %0d chip-select frames where %0d were expected", frame_len.size(), n);
    end
  endtask

  task automatic setup_test(input logic [CLKDIV_W-1:0] div);
    @(posedge clk);
    clk_div <= div;
    cap_bits.delete();
    frame_len.delete();
    resp_q.delete();
  endtask

  // Starts right after a rising edge and ends right after the handshake edge
  task automatic push_word(input logic [31:0] w);
    cmd_valid <= 1'b1;
    cmd_data  <= w;
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (busy) @(negedge clk);
  endtask

  task automatic wait_responses(input int n);
    @(negedge clk);
    while (resp_q.size() < n) @(negedge clk);
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic reset_state_test();
    check_value("cmd_ready", cmd_ready, 1'b0);
    check_value("res_valid", res_valid, 1'b0);
    check_value("busy", busy, 1'b0);
    check_value("spi_clk", spi_clk, 1'b0);
    check_value("spi_sdo", spi_sdo, 1'b0);
    check_value("spi_csn", spi_csn, 1'b1);
  endtask

  task automatic cmd_only_test();
    setup_test(8'd0);
    push_word(make_hdr(8'h06, SEQ_C, SZ_8, SZ_8, 8'd0));
    // Frame opened on the handshake edge
    @(negedge clk);
    check_value("busy", busy, 1'b1);
    wait_idle();
    expect_frames(1);
    check_value("spi_clk rises", frame_len[0], 8);
    check_value("spi_sdo opcode", sent_byte(0), 8'h06);
    // busy drops together with chip select
    check_value("spi_csn", spi_csn, 1'b1);
  endtask

  task automatic cmd_addr_test();
    setup_test(8'd1);
    push_word(make_hdr(8'h20, SEQ_CA, SZ_24, SZ_8, 8'd0));
    push_word(32'h0012_3456);
    wait_idle();
    expect_frames(1);
    check_value("spi_clk rises", frame_len[0], 32);
    check_value("spi_sdo opcode", sent_byte(0), 8'h20);
    check_value("spi_sdo addr byte 0", sent_byte(1), 8'h12);
    check_value("spi_sdo addr byte 1", sent_byte(2), 8'h34);
    check_value("spi_sdo addr byte 2", sent_byte(3), 8'h56);
  endtask

  task automatic addr_write_test();
    logic [31:0] wdata [2];
    wdata[0] = 32'h4433_2211;
    wdata[1] = 32'h8877_6655;
    setup_test(8'd3);
    push_word(make_hdr(8'h02, SEQ_CAW, SZ_24, SZ_8, 8'd8));
    push_word(32'h00ab_cdef);
    push_word(wdata[0]);
    push_word(wdata[1]);
    wait_idle();
    expect_frames(1);
    check_value("spi_clk rises", frame_len[0], 8 + 24 + 64);
    check_value("spi_sdo opcode", sent_byte(0), 8'h02);
    check_value("spi_sdo addr byte 0", sent_byte(1), 8'hab);
    // Low byte of each write word is sent first
    for (int j = 0; j < 2; j++) begin
      for (int k = 0; k < 4; k++) begin
        check_value($sformatf("spi_sdo data byte %0d", 4*j + k),
                    sent_byte(4 + 4*j + k), wdata[j][8*k +: 8]);
      end
    end
  endtask

  task automatic dummy_read_test();
    setup_test(8'd1);
    rand_ready <= 1'b1;
    push_word(make_hdr(8'h0b, SEQ_CADR, SZ_24, SZ_8, 8'd8));
    push_word(32'h0000_0100);
    wait_idle();
    wait_responses(2);
    rand_ready <= 1'b0;
    repeat (4) @(negedge clk);
    expect_frames(1);
    check_value("spi_clk rises", frame_len[0], 8 + 24 + 8 + 64);
    check_value("res_data count", resp_q.size(), 2);
    // Read data starts after 5 bytes of command, address and dummy
    for (int i = 0; i < 2; i++) begin
      check_value($sformatf("res_data %0d", i), resp_q[i], read_word(5 + 4*i));
    end
  endtask

  task automatic back_to_back_test();
    setup_test(8'd0);
    push_word(make_hdr(8'h9f, SEQ_CDR, SZ_8, SZ_8, 8'd4));
    push_word(make_hdr(8'h12, SEQ_CW, SZ_8, SZ_8, 8'd4));
    push_word(32'hdead_beef);
    wait_idle();
    wait_responses(1);
    expect_frames(2);
    check_value("spi_clk rises frame 0", frame_len[0], 8 + 8 + 32);
    check_value("spi_clk rises frame 1", frame_len[1], 8 + 32);
    check_value("res_data 0", resp_q[0], read_word(2));
    check_value("spi_sdo opcode frame 0", sent_byte(0), 8'h9f);
    // Second frame starts at byte 6
    check_value("spi_sdo opcode frame 1", sent_byte(6), 8'h12);
    check_value("spi_sdo data byte 0", sent_byte(7), 8'hef);
    check_value("spi_sdo data byte 3", sent_byte(10), 8'hde);
  endtask

  initial begin
    rstn       = 1'b0;
    clk_div    = '0;
    cmd_valid  = 1'b0;
    cmd_data   = '0;
    res_ready  = 1'b1;
    spi_sdi    = 1'b0;
    errors     = 0;
    checks     = 0;
    seed       = 32'h79d52bae;
    rand_ready = 1'b0;
    sbit       = 0;
    repeat (7) @(posedge clk);
    @(negedge clk);
    reset_state_test();
    @(posedge clk);
    rstn <= 1'b1;
    cmd_only_test();
    cmd_addr_test();
    addr_write_test();
    dummy_read_test();
    back_to_back_test();
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, i_dut.i_chk.fails);
    if ((errors == 0) && (i_dut.i_chk.fails == 0)) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog/spim_clkgen.sv
module spim_clkgen (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              en,
  input  logic [spim_link_pkg::CLKDIV_W-1:0] div,
  output logic                              spi_clk,
  output logic                              rise,
  output logic                              fall
);
  import spim_link_pkg::*;

  logic [CLKDIV_W-1:0] cnt;
  logic                running;
  logic                tick;

  // Keep going while a high half-period is open, so the clock parks low
  assign running = en | spi_clk;
  assign tick    = running && (cnt == '0);

  // Strobes line up with the clk edge that moves spi_clk
  assign rise = tick & ~spi_clk;
  assign fall = tick & spi_clk;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt     <= '0;
      spi_clk <= 1'b0;
    end else if (!running) begin
      // Parked, a restart waits a full half-period
      cnt <= div;
    end else if (cnt == '0) begin
      cnt     <= div;
      spi_clk <= ~spi_clk;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

//--- verilog/spim_cmd_pkg.sv
package spim_cmd_pkg;

  // ----------------------------------------------------------------------
  // Phase sequences selected by the header word
  // ----------------------------------------------------------------------
  // Codes 5 and 6 held the mode-phase reads and now fall back to SEQ_C
  typedef enum logic [3:0] {
    SEQ_C    = 4'd0,   // Command only
    SEQ_CW   = 4'd1,   // Command, write data
    SEQ_CA   = 4'd2,   // Command, address
    SEQ_CAR  = 4'd3,   // Command, address, read data
    SEQ_CADR = 4'd4,   // Command, address, dummy, read data
    SEQ_CAW  = 4'd7,   // Command, address, write data
    SEQ_CADW = 4'd8,   // Command, address, dummy, write data
    SEQ_CDR  = 4'd9,   // Command, dummy, read data
    SEQ_CDW  = 4'd10   // Command, dummy, write data
  } seq_e;

  // Address width or dummy length
  typedef enum logic [1:0] {
    SZ_8  = 2'd0,
    SZ_16 = 2'd1,
    SZ_24 = 2'd2,
    SZ_32 = 2'd3
  } size_e;

  // Header view, declared MSB first
  typedef struct packed {
    logic [7:0] data_bytes;  // Bytes in the write or read phase
    size_e      dummy_size;
    size_e      addr_size;
    seq_e       seq;
    logic [7:0] mode;        // Reserved
    logic [7:0] opcode;
  } cmd_hdr_t;

  // One command-stream word, either a header or a plain address/data word
  typedef union packed {
    cmd_hdr_t    hdr;
    logic [31:0] raw;
  } cmd_word_t;

endpackage

//--- verilog/spim_link_pkg.sv
package spim_link_pkg;

  // Word and counter widths on the serial side
  localparam int WORD_W   = 32;
  localparam int BITCNT_W = 11;   // Up to 255 bytes x 8
  localparam int CLKDIV_W = 8;

  // Chip-select framing in clk cycles
  localparam int CS_SETUP_CYCLES = 2;
  localparam int CS_HOLD_CYCLES  = 2;

  // Serial byte order <-> little-endian word
  function automatic logic [WORD_W-1:0] bswap32(input logic [WORD_W-1:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

endpackage

//--- verilog/spim_rx.sv
module spim_rx (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              rise,
  input  logic                              fall,
  input  logic                              sdi,
  input  logic                              start,
  input  logic [spim_link_pkg::BITCNT_W-1:0] bits,
  output logic                              done,
  output logic                              clk_req,
  output logic                              res_valid,
  input  logic                              res_ready,
  output logic [spim_link_pkg::WORD_W-1:0]   res_data
);
  import spim_link_pkg::*;

  logic [BITCNT_W-1:0] bits_left;
  logic [4:0]          wcnt;
  logic [WORD_W-1:0]   sreg;
  logic                active;
  // Full word waiting for the output register
  logic                pend;
  // Last bit sampled, spi_clk still high
  logic                drain;
  logic                sample;
  logic                move;

  assign clk_req = active && (bits_left != '0) && !pend;
  assign sample  = rise && clk_req;
  // Output register frees up or is already empty
  assign move    = pend && (!res_valid || res_ready);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bits_left <= '0;
      wcnt      <= '0;
      active    <= 1'b0;
      pend      <= 1'b0;
      drain     <= 1'b0;
      done      <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      done <= 1'b0;
      if (res_valid && res_ready) begin
        res_valid <= 1'b0;
      end
      if (move) begin
        res_valid <= 1'b1;
        pend      <= 1'b0;
      end
      if (fall) begin
        drain <= 1'b0;
      end
      if (start) begin
        active    <= 1'b1;
        bits_left <= bits;
        wcnt      <= '0;
      end else if (sample) begin
        bits_left <= bits_left - 1'b1;
        wcnt      <= wcnt + 1'b1;
        // 32nd bit completes the word
        if (wcnt == 5'd31) begin
          pend <= 1'b1;
        end
        if (bits_left == BITCNT_W'(1)) begin
          drain <= 1'b1;
        end
      end else if (active && (bits_left == '0) && !pend && !drain) begin
        // Last word handed over and the clock is back low
        done   <= 1'b1;
        active <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Data path
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (sample) begin
      sreg <= {sreg[WORD_W-2:0], sdi};
    end
    // First byte on the wire lands in bits 7:0
    if (move) begin
      res_data <= bswap32(sreg);
    end
  end

endmodule

//--- verilog/spim_seq_fsm.sv
module spim_seq_fsm (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              cmd_valid,
  output logic                              cmd_ready,
  input  spim_cmd_pkg::cmd_word_t           cmd_data,
  spim_tx_if.seq                            tx,
  output logic                              rx_start,
  output logic [spim_link_pkg::BITCNT_W-1:0] rx_bits,
  input  logic                              rx_done,
  output logic                              busy,
  output logic                              spi_csn
);
  import spim_cmd_pkg::*;
  import spim_link_pkg::*;

  typedef enum logic [3:0] {
    IDLE, CS_SETUP, CMD, ADDR, DUMMY, WRITE, TX_WAIT, READ, CS_HOLD
  } state_e;

  state_e     state;
  state_e     next_state;
  state_e     last_ph;     // Transmit phase that TX_WAIT is waiting on
  cmd_hdr_t   hdr;
  logic       entry;       // First cycle in a state
  logic [2:0] cs_cnt;
  logic [6:0] wr_words;
  logic [8:0] wr_round;

  // Bits for an 8/16/24/32 bit field
  function automatic logic [BITCNT_W-1:0] size_bits(input size_e sz);
    return BITCNT_W'((int'(sz) + 1) * 8);
  endfunction

  // ----------------------------------------------------------------------
  // Phase order after each transmit phase
  // ----------------------------------------------------------------------
  function automatic state_e next_phase(input state_e ph, input seq_e sq);
    state_e nxt;
    nxt = CS_HOLD;
    case (ph)
      CMD: begin
        case (sq)
          SEQ_CW:                                     nxt = WRITE;
          SEQ_CA, SEQ_CAR, SEQ_CADR, SEQ_CAW, SEQ_CADW: nxt = ADDR;
          SEQ_CDR, SEQ_CDW:                           nxt = DUMMY;
          default:                                    nxt = CS_HOLD;
        endcase
      end
      ADDR: begin
        case (sq)
          SEQ_CAR:            nxt = READ;
          SEQ_CADR, SEQ_CADW: nxt = DUMMY;
          SEQ_CAW:            nxt = WRITE;
          default:            nxt = CS_HOLD;
        endcase
      end
      DUMMY: begin
        case (sq)
          SEQ_CADR, SEQ_CDR: nxt = READ;
          SEQ_CADW, SEQ_CDW: nxt = WRITE;
          default:           nxt = CS_HOLD;
        endcase
      end
      default: nxt = CS_HOLD;
    endcase
    return nxt;
  endfunction

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      IDLE:     if (cmd_valid) next_state = CS_SETUP;
      CS_SETUP: if (cs_cnt == 3'(CS_SETUP_CYCLES - 1)) next_state = CMD;
      CMD:      if (tx.ready) next_state = TX_WAIT;
      ADDR:     if (cmd_valid && tx.ready) next_state = TX_WAIT;
      DUMMY:    if (tx.ready) next_state = TX_WAIT;
      // Leave once the final write word is in the shifter
      WRITE:    if (cmd_valid && tx.ready && (wr_words == 7'd1)) next_state = TX_WAIT;
      TX_WAIT:  if (tx.done) next_state = next_phase(last_ph, hdr.seq);
      READ:     if (rx_done) next_state = CS_HOLD;
      CS_HOLD:  if (cs_cnt == 3'(CS_HOLD_CYCLES - 1)) next_state = IDLE;
      default:  next_state = IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // Transmit word per phase
  // ----------------------------------------------------------------------
  always_comb begin
    tx.data  = '0;
    tx.valid = 1'b0;
    tx.bits  = size_bits(SZ_8);
    case (state)
      CMD: begin
        tx.data  = {hdr.opcode, 24'h0};
        tx.valid = 1'b1;
      end
      ADDR: begin
        // Low bytes of the address word, left-aligned
        case (hdr.addr_size)
          SZ_8:    tx.data = {cmd_data.raw[7:0], 24'h0};
          SZ_16:   tx.data = {cmd_data.raw[15:0], 16'h0};
          SZ_24:   tx.data = {cmd_data.raw[23:0], 8'h0};
          default: tx.data = cmd_data.raw;
        endcase
        tx.valid = cmd_valid;
        tx.bits  = size_bits(hdr.addr_size);
      end
      DUMMY: begin
        tx.valid = 1'b1;
        tx.bits  = size_bits(hdr.dummy_size);
      end
      WRITE: begin
        tx.data  = bswap32(cmd_data.raw);
        tx.valid = cmd_valid;
        tx.bits  = {hdr.data_bytes, 3'b000};
      end
      default: ;
    endcase
  end

  // Load the bit count as each transmit phase opens
  assign tx.load  = entry && (state inside {CMD, ADDR, DUMMY, WRITE});
  assign rx_start = entry && (state == READ);
  assign rx_bits  = {hdr.data_bytes, 3'b000};

  // Header in idle, address and write words from their phases
  always_comb begin
    cmd_ready = 1'b0;
    case (state)
      IDLE:        cmd_ready = cmd_valid;
      ADDR, WRITE: cmd_ready = tx.ready;
      default:     cmd_ready = 1'b0;
    endcase
  end

  // Write words, rounded up
  assign wr_round = {1'b0, cmd_data.hdr.data_bytes} + 9'd3;

  assign busy = ~spi_csn;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state    <= IDLE;
      last_ph  <= IDLE;
      hdr      <= '0;
      entry    <= 1'b0;
      cs_cnt   <= '0;
      wr_words <= '0;
      spi_csn  <= 1'b1;
    end else begin
      state   <= next_state;
      entry   <= (next_state != state);
      spi_csn <= (next_state == IDLE);
      // Setup and hold counter restarts on every state change
      if (next_state != state) begin
        cs_cnt <= '0;
      end else begin
        cs_cnt <= cs_cnt + 1'b1;
      end
      if ((state == IDLE) && cmd_valid) begin
        hdr      <= cmd_data.hdr;
        wr_words <= wr_round[8:2];
      end
      if (state inside {CMD, ADDR, DUMMY, WRITE}) begin
        last_ph <= state;
      end
      if ((state == WRITE) && cmd_valid && tx.ready) begin
        wr_words <= wr_words - 1'b1;
      end
    end
  end

endmodule

//--- verilog/spim_top.sv
module spim_top (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic [spim_link_pkg::CLKDIV_W-1:0] clk_div,
  input  logic                              cmd_valid,
  output logic                              cmd_ready,
  input  logic [spim_link_pkg::WORD_W-1:0]   cmd_data,
  output logic                              res_valid,
  input  logic                              res_ready,
  output logic [spim_link_pkg::WORD_W-1:0]   res_data,
  output logic                              busy,
  output logic                              spi_clk,
  output logic                              spi_csn,
  output logic                              spi_sdo,
  input  logic                              spi_sdi
);
  import spim_link_pkg::*;

  logic                spi_rise;
  logic                spi_fall;
  logic                tx_clk_req;
  logic                rx_clk_req;
  logic                rx_start;
  logic [BITCNT_W-1:0] rx_bits;
  logic                rx_done;

  spim_tx_if tx_link ();

  // ----------------------------------------------------------------------
  // Sequencer and serial datapath
  // ----------------------------------------------------------------------
  spim_seq_fsm i_seq (
    .clk      (clk),
    .rstn     (rstn),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_data (cmd_data),
    .tx       (tx_link.seq),
    .rx_start (rx_start),
    .rx_bits  (rx_bits),
    .rx_done  (rx_done),
    .busy     (busy),
    .spi_csn  (spi_csn)
  );

  // Either shifter may keep the SPI clock running
  spim_clkgen i_clkgen (
    .clk    (clk),
    .rstn   (rstn),
    .en     (tx_clk_req | rx_clk_req),
    .div    (clk_div),
    .spi_clk(spi_clk),
    .rise   (spi_rise),
    .fall   (spi_fall)
  );

  spim_tx i_tx (
    .clk    (clk),
    .rstn   (rstn),
    .fall   (spi_fall),
    .link   (tx_link.tx),
    .clk_req(tx_clk_req),
    .sdo    (spi_sdo)
  );

  spim_rx i_rx (
    .clk      (clk),
    .rstn     (rstn),
    .rise     (spi_rise),
    .fall     (spi_fall),
    .sdi      (spi_sdi),
    .start    (rx_start),
    .bits     (rx_bits),
    .done     (rx_done),
    .clk_req  (rx_clk_req),
    .res_valid(res_valid),
    .res_ready(res_ready),
    .res_data (res_data)
  );

endmodule

//--- verilog/spim_tx.sv
module spim_tx (
  input  logic  clk,
  input  logic  rstn,
  input  logic  fall,
  spim_tx_if.tx link,
  output logic  clk_req,
  output logic  sdo
);
  import spim_link_pkg::*;

  logic [BITCNT_W-1:0] bits_left;
  logic [BITCNT_W-1:0] ph_bits;
  logic [WORD_W-1:0]   sreg;
  // Bits of the current word still to go out, zero when empty
  logic [5:0]          word_bits;
  logic [5:0]          first_bits;
  logic                take;

  // ----------------------------------------------------------------------
  // Word intake
  // ----------------------------------------------------------------------
  // A word may arrive in the same cycle as the load pulse
  assign ph_bits    = link.load ? link.bits : bits_left;
  assign first_bits = (ph_bits >= BITCNT_W'(WORD_W)) ? 6'(WORD_W) : ph_bits[5:0];

  assign link.ready = (word_bits == '0);
  assign take       = link.valid && link.ready;

  // Clock only while a loaded word has bits left
  assign clk_req = (word_bits != '0);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bits_left <= '0;
      word_bits <= '0;
      sdo       <= 1'b0;
      link.done <= 1'b0;
    end else begin
      link.done <= 1'b0;
      if (link.load) begin
        bits_left <= link.bits;
      end
      if (take) begin
        // MSB shows up on the line right away
        word_bits <= first_bits;
        sdo       <= link.data[WORD_W-1];
      end else if (fall && (word_bits != '0)) begin
        word_bits <= word_bits - 1'b1;
        bits_left <= bits_left - 1'b1;
        // The last bit of a word stays on the line
        if (word_bits != 6'd1) begin
          sdo <= sreg[WORD_W-1];
        end
        if (bits_left == BITCNT_W'(1)) begin
          link.done <= 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Shift register, MSB first
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (take) begin
      sreg <= link.data << 1;
    end else if (fall && (word_bits > 6'd1)) begin
      sreg <= sreg << 1;
    end
  end

endmodule

//--- verilog/spim_tx_if.sv
interface spim_tx_if;
  import spim_link_pkg::*;

  // Word offered to the shifter, MSB goes out first
  logic [WORD_W-1:0]   data;
  logic                valid;
  logic                ready;
  // Phase bit count, taken on the load pulse
  logic [BITCNT_W-1:0] bits;
  logic                load;
  // Last bit of the phase has finished
  logic                done;

  modport seq (
    output data, valid, bits, load,
    input  ready, done
  );

  modport tx (
    input  data, valid, bits, load,
    output ready, done
  );

endinterface

//--- vlog.f
verilog/spim_cmd_pkg.sv
verilog/spim_link_pkg.sv
verilog/spim_tx_if.sv
verilog/spim_clkgen.sv
verilog/spim_tx.sv
verilog/spim_rx.sv
verilog/spim_seq_fsm.sv
verilog/spim_top.sv
verif/spim_chk.sv
verif/spim_tb.sv
